// ==== logic/apu_square_config.svh ====
//==========================================================================
// APU pulse voice widths and counts shared by the RTL and the testbench
//==========================================================================

`ifndef APU_SQUARE_CONFIG_SVH
`define APU_SQUARE_CONFIG_SVH

// Timer period, 11 bits as on the real chip
`define APU_PERIOD_W 11

// Volume, decay and output sample
`define APU_VOL_W 4

// Sweep shift count
`define APU_SHIFT_W 3

`define APU_LEN_W 8 // Length counter
`define APU_LEN_IDX_W 5 // Length table index

// Duty sequencer steps per cycle
`define APU_DUTY_STEPS 8

`endif

// ==== logic/apu_reg_pkg.sv ====
//==========================================================================
// APU pulse register map: register select and control field layouts
//==========================================================================

`default_nettype none

`include "apu_square_config.svh"

package apu_reg_pkg;

	typedef enum logic [1:0] {
		reg_ctrl      = 2'd0, // Duty and envelope
		reg_sweep     = 2'd1,
		reg_period_lo = 2'd2,
		reg_period_hi = 2'd3  // Period high and length index
	} reg_sel_t;

	typedef struct packed {
		logic                  loop_halt; // Envelope loop and length halt
		logic                  const_vol;
		logic [`APU_VOL_W-1:0] vol;
	} env_ctrl_t;

	typedef struct packed {
		logic                    enable;
		logic [2:0]              div_period;
		logic                    negate;
		logic [`APU_SHIFT_W-1:0] shift;
	} sweep_ctrl_t;

endpackage

`default_nettype wire

// ==== logic/apu_seq_pkg.sv ====
//==========================================================================
// APU pulse sequencing types for the duty sequencer and envelope
//==========================================================================

`default_nettype none

package apu_seq_pkg;

	typedef enum logic [1:0] {
		duty_12 = 2'd0,
		duty_25 = 2'd1,
		duty_50 = 2'd2,
		duty_75 = 2'd3 // Inverted 25%
	} duty_mode_t;

	// Start flag, set on restart and taken on the next quarter frame
	typedef enum logic {
		env_idle  = 1'b0,
		env_start = 1'b1
	} env_state_t;

endpackage

`default_nettype wire

// ==== logic/square_regs_if.sv ====
//==========================================================================
// Pulse voice register bus: decoded fields and write pulses to the units
//==========================================================================

`timescale 1ns/1ps
`default_nettype none

`include "apu_square_config.svh"

interface square_regs_if;

	apu_seq_pkg::duty_mode_t  duty;
	apu_reg_pkg::env_ctrl_t   env;
	apu_reg_pkg::sweep_ctrl_t sweep;
	logic                     sweep_wr; // Sets the sweep reload flag

	logic                     period_lo_wr;
	logic [7:0]               period_lo;
	logic                     period_hi_wr;
	logic [2:0]               period_hi;

	logic [`APU_LEN_IDX_W-1:0] len_index;
	logic                      restart; // Length load, envelope start, step reset

	modport regs (
		output duty, env, sweep, sweep_wr,
		output period_lo_wr, period_lo, period_hi_wr, period_hi,
		output len_index, restart
	);

	modport unit (
		input duty, env, sweep, sweep_wr,
		input period_lo_wr, period_lo, period_hi_wr, period_hi,
		input len_index, restart
	);

endinterface

`default_nettype wire

// ==== logic/square_reg_file.sv ====
//==========================================================================
// Pulse register file that decodes byte writes into fields and pulses
//==========================================================================

`timescale 1ns/1ps
`default_nettype none

module square_reg_file (
	input  wire                   aclk,
	input  wire                   rst_n,
	input  wire                   reg_wr,
	input  apu_reg_pkg::reg_sel_t reg_addr,
	input  wire [7:0]             reg_data,
	square_regs_if.regs           regs
);

	always_ff @(posedge aclk) begin
		if (!rst_n) begin
			regs.duty         <= apu_seq_pkg::duty_12;
			regs.env          <= '0;
			regs.sweep        <= '0;
			regs.sweep_wr     <= 1'b0;
			regs.period_lo_wr <= 1'b0;
			regs.period_lo    <= '0;
			regs.period_hi_wr <= 1'b0;
			regs.period_hi    <= '0;
			regs.len_index    <= '0;
			regs.restart      <= 1'b0;
		end else begin
			// Pulses last one cycle
			regs.sweep_wr     <= 1'b0;
			regs.period_lo_wr <= 1'b0;
			regs.period_hi_wr <= 1'b0;
			regs.restart      <= 1'b0;

			if (reg_wr) begin
				case (reg_addr)
					apu_reg_pkg::reg_ctrl: begin
						regs.duty <= apu_seq_pkg::duty_mode_t'(reg_data[7:6]);
						regs.env  <= apu_reg_pkg::env_ctrl_t'(reg_data[5:0]);
					end
					apu_reg_pkg::reg_sweep: begin
						regs.sweep    <= apu_reg_pkg::sweep_ctrl_t'(reg_data);
						regs.sweep_wr <= 1'b1;
					end
					apu_reg_pkg::reg_period_lo: begin
						regs.period_lo    <= reg_data;
						regs.period_lo_wr <= 1'b1;
					end
					apu_reg_pkg::reg_period_hi: begin
						regs.period_hi    <= reg_data[2:0];
						regs.len_index    <= reg_data[7:3];
						regs.period_hi_wr <= 1'b1;
						regs.restart      <= 1'b1; // Also requests envelope start
					end
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// ==== logic/square_timer_sweep.sv ====
//==========================================================================
// Pulse period timer and sweep unit with shifter, adder and mute check
//==========================================================================

`timescale 1ns/1ps
`default_nettype none

`include "apu_square_config.svh"

module square_timer_sweep #(
	parameter bit ones_complement_neg = 1'b0 // 1: negate subtracts one more
) (
	input  wire         aclk,
	input  wire         rst_n,
	input  wire         half_frame,
	square_regs_if.unit regs,
	output logic        timer_tick,
	output logic        sweep_mute
);

	logic [`APU_PERIOD_W-1:0] period;
	logic [`APU_PERIOD_W-1:0] timer_cnt;
	logic [`APU_PERIOD_W-1:0] shift_s1;
	logic [`APU_PERIOD_W-1:0] shift_s2;
	logic [`APU_PERIOD_W-1:0] change;
	logic [`APU_PERIOD_W:0]   sum; // Top bit is the carry
	logic [`APU_PERIOD_W-1:0] target;
	logic [2:0]               div_cnt;
	logic                     reload_flag;
	logic                     sweep_update;

	// Barrel shifter in three stages of 1, 2 and 4
	always_comb begin
		shift_s1 = regs.sweep.shift[0] ? (period >> 1) : period;
		shift_s2 = regs.sweep.shift[1] ? (shift_s1 >> 2) : shift_s1;
		change   = regs.sweep.shift[2] ? (shift_s2 >> 4) : shift_s2;
	end

	always_comb begin
		if (regs.sweep.negate) begin
			sum = {1'b0, period} - {1'b0, change}
				- {{`APU_PERIOD_W{1'b0}}, ones_complement_neg};
		end else begin
			sum = {1'b0, period} + {1'b0, change};
		end
	end

	assign target = sum[`APU_PERIOD_W-1:0];

	// Low period or add overflow
	assign sweep_mute = (period[`APU_PERIOD_W-1:3] == '0)
		| (~regs.sweep.negate & sum[`APU_PERIOD_W]);

	assign sweep_update = half_frame & (div_cnt == 3'd0) & regs.sweep.enable
		& (regs.sweep.shift != '0) & ~sweep_mute;

	always_ff @(posedge aclk) begin
		if (!rst_n) begin
			period <= '0;
		end else begin
			if (sweep_update) begin
				period <= target;
			end
			if (regs.period_lo_wr) begin
				period[7:0] <= regs.period_lo; // CPU write wins over sweep
			end
			if (regs.period_hi_wr) begin
				period[`APU_PERIOD_W-1:8] <= regs.period_hi;
			end
		end
	end

	always_ff @(posedge aclk) begin
		if (!rst_n) begin
			timer_cnt  <= '0;
			timer_tick <= 1'b0;
		end else if (timer_cnt == '0) begin
			timer_cnt  <= period;
			timer_tick <= 1'b1;
		end else begin
			timer_cnt  <= timer_cnt - 1'b1;
			timer_tick <= 1'b0;
		end
	end

	always_ff @(posedge aclk) begin
		if (!rst_n) begin
			div_cnt     <= '0;
			reload_flag <= 1'b0;
		end else begin
			if (half_frame) begin
				if ((div_cnt == 3'd0) || reload_flag) begin
					div_cnt     <= regs.sweep.div_period;
					reload_flag <= 1'b0;
				end else begin
					div_cnt <= div_cnt - 1'b1;
				end
			end
			if (regs.sweep_wr) begin
				reload_flag <= 1'b1; // Reload on the next half frame
			end
		end
	end

endmodule

`default_nettype wire

// ==== logic/square_env_length.sv ====
//==========================================================================
// Pulse envelope generator and length counter with the length table
//==========================================================================

`timescale 1ns/1ps
`default_nettype none

`include "apu_square_config.svh"

module square_env_length (
	input  wire                         aclk,
	input  wire                         rst_n,
	input  wire                         quarter_frame,
	input  wire                         half_frame,
	square_regs_if.unit                 regs,
	output logic [`APU_VOL_W-1:0]       volume,
	output logic                        length_active
);

	localparam logic [`APU_LEN_W-1:0] len_table [32] = '{
		8'd10,  8'd254, 8'd20,  8'd2,  8'd40, 8'd4,  8'd80, 8'd6,
		8'd160, 8'd8,   8'd60,  8'd10, 8'd14, 8'd12, 8'd26, 8'd14,
		8'd12,  8'd16,  8'd24,  8'd18, 8'd48, 8'd20, 8'd96, 8'd22,
		8'd192, 8'd24,  8'd72,  8'd26, 8'd16, 8'd28, 8'd32, 8'd30
	};

	apu_seq_pkg::env_state_t   env_state;
	logic [`APU_VOL_W-1:0]     env_div;
	logic [`APU_VOL_W-1:0]     decay;
	logic [`APU_LEN_W-1:0]     len_cnt;

	always_ff @(posedge aclk) begin
		if (!rst_n) begin
			env_state <= apu_seq_pkg::env_idle;
			env_div   <= '0;
			decay     <= '0;
		end else begin
			if (quarter_frame) begin
				if (env_state == apu_seq_pkg::env_start) begin
					decay     <= '1;
					env_div   <= regs.env.vol;
					env_state <= apu_seq_pkg::env_idle;
				end else if (env_div == '0) begin
					env_div <= regs.env.vol;
					if (decay != '0) begin
						decay <= decay - 1'b1;
					end else if (regs.env.loop_halt) begin
						decay <= '1; // Loop back to 15
					end
				end else begin
					env_div <= env_div - 1'b1;
				end
			end
			if (regs.restart) begin
				env_state <= apu_seq_pkg::env_start;
			end
		end
	end

	assign volume = regs.env.const_vol ? regs.env.vol : decay;

	always_ff @(posedge aclk) begin
		if (!rst_n) begin
			len_cnt <= '0;
		end else if (regs.restart) begin
			len_cnt <= len_table[regs.len_index];
		end else if (half_frame && (len_cnt != '0) && !regs.env.loop_halt) begin
			len_cnt <= len_cnt - 1'b1;
		end
	end

	assign length_active = (len_cnt != '0);

endmodule

`default_nettype wire

// ==== logic/square_output.sv ====
//==========================================================================
// Pulse duty sequencer and registered output gate
//==========================================================================

`timescale 1ns/1ps
`default_nettype none

`include "apu_square_config.svh"

module square_output (
	input  wire                   aclk,
	input  wire                   rst_n,
	input  wire                   timer_tick,
	input  wire                   sweep_mute,
	input  wire [`APU_VOL_W-1:0]  volume,
	input  wire                   length_active,
	input  wire                   lock,
	square_regs_if.unit           regs,
	output logic [`APU_VOL_W-1:0] sq_out
);

	localparam int step_w = $clog2(`APU_DUTY_STEPS);

	logic [step_w-1:0]          step;
	logic [`APU_DUTY_STEPS-1:0] pattern; // Bit i is step i
	logic                       duty_bit;

	always_comb begin
		case (regs.duty)
			apu_seq_pkg::duty_12: pattern = 8'b0000_0010;
			apu_seq_pkg::duty_25: pattern = 8'b0000_0110;
			apu_seq_pkg::duty_50: pattern = 8'b0001_1110;
			default:              pattern = 8'b1111_1001;
		endcase
	end

	assign duty_bit = pattern[step];

	always_ff @(posedge aclk) begin
		if (!rst_n) begin
			step <= '0;
		end else if (regs.restart) begin
			step <= '0;
		end else if (timer_tick) begin
			step <= step - 1'b1; // Counts down as on the chip
		end
	end

	always_ff @(posedge aclk) begin
		if (!rst_n) begin
			sq_out <= '0;
		end else if (duty_bit && length_active && !sweep_mute && !lock) begin
			sq_out <= volume;
		end else begin
			sq_out <= '0;
		end
	end

endmodule

`default_nettype wire

// ==== logic/apu_square.sv ====
//==========================================================================
// APU pulse voice top: register file, timer and sweep, envelope, output
//==========================================================================

`timescale 1ns/1ps
`default_nettype none

`include "apu_square_config.svh"

module apu_square #(
	parameter bit ones_complement_neg = 1'b0 // Set for the first pulse voice
) (
	input  wire                   aclk,
	input  wire                   rst_n,
	input  wire                   reg_wr,
	input  wire [1:0]             reg_addr,
	input  wire [7:0]             reg_data,
	input  wire                   quarter_frame,
	input  wire                   half_frame,
	input  wire                   lock,
	output wire [`APU_VOL_W-1:0]  sq_out,
	output wire                   length_active
);

	wire                  timer_tick;
	wire                  sweep_mute;
	wire [`APU_VOL_W-1:0] volume;

	square_regs_if regs_if ();

	square_reg_file square_reg_file_inst (
		.aclk     (aclk),
		.rst_n    (rst_n),
		.reg_wr   (reg_wr),
		.reg_addr (apu_reg_pkg::reg_sel_t'(reg_addr)),
		.reg_data (reg_data),
		.regs     (regs_if.regs)
	);

	square_timer_sweep #(
		.ones_complement_neg (ones_complement_neg)
	) square_timer_sweep_inst (
		.aclk       (aclk),
		.rst_n      (rst_n),
		.half_frame (half_frame),
		.regs       (regs_if.unit),
		.timer_tick (timer_tick),
		.sweep_mute (sweep_mute)
	);

	square_env_length square_env_length_inst (
		.aclk          (aclk),
		.rst_n         (rst_n),
		.quarter_frame (quarter_frame),
		.half_frame    (half_frame),
		.regs          (regs_if.unit),
		.volume        (volume),
		.length_active (length_active)
	);

	square_output square_output_inst (
		.aclk          (aclk),
		.rst_n         (rst_n),
		.timer_tick    (timer_tick),
		.sweep_mute    (sweep_mute),
		.volume        (volume),
		.length_active (length_active),
		.lock          (lock),
		.regs          (regs_if.unit),
		.sq_out        (sq_out)
	);

endmodule

`default_nettype wire

// ==== sim/apu_square_tb.sv ====
//==========================================================================
// Pulse voice testbench with LFSR stimulus checked against a cycle model
//==========================================================================

`timescale 1ns/1ps
`default_nettype none

`include "apu_square_config.svh"

module apu_square_tb;

	localparam bit ones_neg = 1'b1;
	localparam int duty_cycles = 8 * 256 + 40;
	localparam int length_cycles = 4 * 256 + 260;
	localparam int env_cycles = 2 * 320;
	localparam int sweep_cycles = 4 * 420;
	localparam int lock_cycles = 120;
	localparam int setup_cycles = 12 * 10; // Four writes per voice setup
	localparam int timeout_cycles = 5 + duty_cycles + length_cycles + env_cycles
		+ sweep_cycles + lock_cycles + setup_cycles + 500;

	// Standard length table, index 0 first
	localparam int len_table [32] = '{
		10, 254, 20, 2, 40, 4, 80, 6, 160, 8, 60, 10, 14, 12, 26, 14,
		12, 16, 24, 18, 48, 20, 96, 22, 192, 24, 72, 26, 16, 28, 32, 30
	};

	logic aclk;
	logic rst_n;
	logic reg_wr;
	apu_reg_pkg::reg_sel_t reg_addr;
	logic [7:0] reg_data;
	logic quarter_frame;
	logic half_frame;
	logic lock;
	wire [`APU_VOL_W-1:0] sq_out;
	wire length_active;

	// Cycle model state
	apu_seq_pkg::duty_mode_t m_duty;
	apu_reg_pkg::env_ctrl_t m_env;
	apu_reg_pkg::sweep_ctrl_t m_sweep;
	logic m_sweep_wr, m_lo_wr, m_hi_wr, m_restart;
	logic [7:0] m_lo;
	logic [2:0] m_hi;
	logic [4:0] m_len_idx;
	logic [`APU_PERIOD_W-1:0] m_period, m_timer;
	logic m_tick, m_reload, m_start;
	logic [2:0] m_step, m_div;
	logic [`APU_VOL_W-1:0] m_ediv, m_decay, m_out;
	logic [`APU_LEN_W-1:0] m_len;

	logic [15:0] lfsr;
	int cycles;
	int errors;
	int n_checks;
	int n_tests;
	int test_errors;

	apu_square #(
		.ones_complement_neg (ones_neg)
	) apu_square_inst (
		.aclk          (aclk),
		.rst_n         (rst_n),
		.reg_wr        (reg_wr),
		.reg_addr      (reg_addr),
		.reg_data      (reg_data),
		.quarter_frame (quarter_frame),
		.half_frame    (half_frame),
		.lock          (lock),
		.sq_out        (sq_out),
		.length_active (length_active)
	);

	initial begin
		aclk = 1'b0;
		forever #2 aclk = ~aclk;
	end

	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr[0]};
			lfsr = lfsr_next(lfsr);
		end
		return v;
	endfunction

	function automatic logic duty_high(input apu_seq_pkg::duty_mode_t d, input logic [2:0] s);
		logic [0:7] p; // Leftmost bit is step 0
		case (d)
			apu_seq_pkg::duty_12: p = 8'b01000000;
			apu_seq_pkg::duty_25: p = 8'b01100000;
			apu_seq_pkg::duty_50: p = 8'b01111000;
			default:              p = 8'b10011111;
		endcase
		return p[s];
	endfunction

	task automatic clear_model();
		m_duty = apu_seq_pkg::duty_12;
		m_env = '0;
		m_sweep = '0;
		{m_sweep_wr, m_lo_wr, m_hi_wr, m_restart, m_tick, m_reload, m_start} = '0;
		{m_lo, m_hi, m_len_idx, m_period, m_timer, m_step, m_div} = '0;
		{m_ediv, m_decay, m_out, m_len} = '0;
	endtask

	// Units are updated consumer first so every rule sees last cycle's state
	task automatic advance_model();
		logic [`APU_PERIOD_W-1:0] chg;
		logic [`APU_PERIOD_W:0] tgt;
		logic mute;
		chg = m_period >> m_sweep.shift;
		if (m_sweep.negate)
			tgt = {1'b0, m_period} - {1'b0, chg} - (ones_neg ? 12'd1 : 12'd0);
		else
			tgt = {1'b0, m_period} + {1'b0, chg};
		mute = (m_period < 11'd8) || (!m_sweep.negate && tgt > 12'h7FF);
		if (duty_high(m_duty, m_step) && m_len != '0 && !mute && !lock)
			m_out = m_env.const_vol ? m_env.vol : m_decay;
		else
			m_out = '0;
		if (m_restart)
			m_step = 3'd0;
		else if (m_tick)
			m_step = m_step - 3'd1;
		m_tick = (m_timer == '0);
		m_timer = m_tick ? m_period : m_timer - 11'd1;
		if (half_frame && m_div == 3'd0 && m_sweep.enable && m_sweep.shift != '0 && !mute)
			m_period = tgt[`APU_PERIOD_W-1:0];
		if (m_lo_wr)
			m_period[7:0] = m_lo;
		if (m_hi_wr)
			m_period[10:8] = m_hi;
		if (half_frame && (m_div == 3'd0 || m_reload)) begin
			m_div = m_sweep.div_period;
			m_reload = 1'b0;
		end else if (half_frame) begin
			m_div = m_div - 3'd1;
		end
		m_reload = m_reload | m_sweep_wr;
		if (quarter_frame && m_start) begin
			m_decay = 4'd15;
			m_ediv = m_env.vol;
			m_start = 1'b0;
		end else if (quarter_frame && m_ediv == '0) begin
			m_ediv = m_env.vol;
			if (m_decay != '0)
				m_decay = m_decay - 4'd1;
			else if (m_env.loop_halt)
				m_decay = 4'd15; // Loop back
		end else if (quarter_frame) begin
			m_ediv = m_ediv - 4'd1;
		end
		m_start = m_start | m_restart;
		if (m_restart)
			m_len = 8'(len_table[m_len_idx]);
		else if (half_frame && m_len != '0 && !m_env.loop_halt)
			m_len = m_len - 8'd1;
		{m_sweep_wr, m_lo_wr, m_hi_wr, m_restart} = '0;
		if (reg_wr) begin
			case (reg_addr)
				apu_reg_pkg::reg_ctrl: begin
					m_duty = apu_seq_pkg::duty_mode_t'(reg_data[7:6]);
					m_env.loop_halt = reg_data[5];
					m_env.const_vol = reg_data[4];
					m_env.vol = reg_data[3:0];
				end
				apu_reg_pkg::reg_sweep: begin
					m_sweep.enable = reg_data[7];
					m_sweep.div_period = reg_data[6:4];
					m_sweep.negate = reg_data[3];
					m_sweep.shift = reg_data[2:0];
					m_sweep_wr = 1'b1;
				end
				apu_reg_pkg::reg_period_lo: begin
					m_lo = reg_data;
					m_lo_wr = 1'b1;
				end
				default: begin
					m_hi = reg_data[2:0];
					m_len_idx = reg_data[7:3];
					m_hi_wr = 1'b1;
					m_restart = 1'b1;
				end
			endcase
		end
	endtask

	always @(posedge aclk) begin
		if (!rst_n)
			clear_model();
		else
			advance_model();
		cycles++;
		if (cycles >= timeout_cycles) begin
			$display("Timeout: the run did not finish within %0d cycles", timeout_cycles);
			$display("=== FAIL ===");
			$finish;
		end
	end

	task automatic check_sample(input logic [`APU_VOL_W-1:0] got,
		input logic [`APU_VOL_W-1:0] exp);
		n_checks++;
		if (got !== exp) begin
			errors++;
			$display("[ERROR] %0t ns: sq_out is %0d, model expects %0d", $time, got, exp);
		end
	endtask

	task automatic check_active(input logic got, input logic exp);
		n_checks++;
		if (got !== exp) begin
			errors++;
			$display("[ERROR] %0t ns: length_active is %b, model expects %b", $time, got, exp);
		end
	endtask

	// Outputs are stable half a cycle after the edge
	always @(negedge aclk) begin
		check_sample(sq_out, m_out);
		check_active(length_active, m_len != '0);
	end

	task automatic write_reg(input apu_reg_pkg::reg_sel_t a, input logic [7:0] d);
		@(posedge aclk);
		reg_wr <= 1'b1;
		reg_addr <= a;
		reg_data <= d;
		@(posedge aclk);
		reg_wr <= 1'b0;
	endtask

	task automatic setup_voice(input logic [7:0] ctrl, input logic [7:0] sweep,
		input logic [10:0] period, input logic [4:0] len_idx);
		write_reg(apu_reg_pkg::reg_ctrl, ctrl);
		write_reg(apu_reg_pkg::reg_sweep, sweep);
		write_reg(apu_reg_pkg::reg_period_lo, period[7:0]);
		write_reg(apu_reg_pkg::reg_period_hi, {len_idx, period[10:8]});
	endtask

	// Strobe chance is one in 2**bits or never for zero bits
	task automatic run_random(input int n, input int q_bits, input int h_bits);
		repeat (n) begin
			@(posedge aclk);
			quarter_frame <= (q_bits != 0) && (rand_bits(q_bits) == '0);
			half_frame <= (h_bits != 0) && (rand_bits(h_bits) == '0);
		end
		@(posedge aclk);
		quarter_frame <= 1'b0;
		half_frame <= 1'b0;
	endtask

	task automatic end_test(input string name);
		n_tests++;
		$display("Test %s finished with %0d errors", name, errors - test_errors);
		test_errors = errors;
	endtask

	initial begin
		logic [10:0] p;
		logic [7:0] sw;
		lfsr = 16'd36;
		{cycles, errors, n_checks, n_tests, test_errors} = '0;
		rst_n = 1'b0;
		reg_wr = 1'b0;
		reg_addr = apu_reg_pkg::reg_ctrl;
		reg_data = 8'h00;
		quarter_frame = 1'b0;
		half_frame = 1'b0;
		lock = 1'b0;
		repeat (5) @(posedge aclk);
		rst_n <= 1'b1;
		run_random(4, 0, 0);
		end_test("reset");

		p = 11'(rand_bits(8));
		if (p < 11'd8)
			p = p + 11'd8;
		setup_voice({2'(rand_bits(2)), 3'b111, 3'(rand_bits(3))}, 8'h00, p, 5'd1);
		run_random(8 * (int'(p) + 1) + 16, 0, 0);
		end_test("duty");

		setup_voice({2'b10, 3'b011, 3'b111}, 8'h00, 11'd8, 5'(rand_bits(5)));
		run_random(2, 0, 0);
		@(negedge aclk);
		while (length_active) begin
			@(posedge aclk);
			half_frame <= (rand_bits(1) != '0);
			@(negedge aclk);
		end
		run_random(40, 0, 1);
		setup_voice({2'b10, 3'b111, 3'b111}, 8'h00, 11'd8, 5'(rand_bits(5)));
		run_random(200, 0, 1);
		end_test("length");

		for (int lh = 0; lh < 2; lh++) begin
			setup_voice({2'b10, 1'(lh), 3'b000, 2'(rand_bits(2))}, 8'h00, 11'd8, 5'd1);
			run_random(300, 1, 0);
		end
		end_test("envelope");

		for (int i = 0; i < 4; i++) begin
			sw = 8'(rand_bits(8));
			if (i == 0) begin
				p = 11'(rand_bits(3)); // Muted by a low period
			end else if (i == 1) begin
				p = {1'b1, 10'(rand_bits(10))};
				sw[3:0] = 4'd0; // Add with zero shift always overflows
			end else begin
				p = 11'(rand_bits(6)) + 11'd8; // Short steps show each update
				sw[7] = 1'b1;
				sw[3] = (i == 3);
				if (sw[2:0] == 3'd0)
					sw[2:0] = 3'd1;
			end
			setup_voice(8'hFF, sw, p, 5'd1);
			run_random(400, 0, 3);
		end
		end_test("sweep");

		setup_voice({2'b10, 3'b011, 3'(rand_bits(3))}, 8'h00, 11'd8 + 11'(rand_bits(3)), 5'd1);
		run_random(30, 0, 0);
		@(posedge aclk);
		lock <= 1'b1;
		run_random(50, 0, 1);
		@(posedge aclk);
		lock <= 1'b0;
		run_random(20, 0, 0);
		end_test("lock");

		$display("Tests %0d, checks %0d, errors %0d", n_tests, n_checks, errors);
		if (errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+logic
logic/apu_reg_pkg.sv
logic/apu_seq_pkg.sv
logic/square_regs_if.sv
logic/square_reg_file.sv
logic/square_timer_sweep.sv
logic/square_env_length.sv
logic/square_output.sv
logic/apu_square.sv
sim/apu_square_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= apu_square_tb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	! grep -q "=== FAIL ===" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
